// File: runSim.sh
#!/usr/bin/env bash
# builds and runs the rv32Core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f rv32Core.f --top-module rv32CoreTb -o rv32CoreSim

./obj_dir/rv32CoreSim | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// File: rv32Core.f
rv32Pkg.sv
rv32CtrlIf.sv
rv32Decoder.sv
rv32RegFile.sv
rv32LoadStore.sv
rv32Execute.sv
rv32Core.sv
rv32CoreTb.sv

// File: rv32Core.sv
`default_nettype none

module rv32Core #(
	parameter rv32Pkg::word_t resetPc = '0
) (
	input  logic             clk,
	input  logic             rstN,
	output rv32Pkg::word_t   pc,
	input  rv32Pkg::word_t   inst,
	output rv32Pkg::word_t   memAddr,
	output rv32Pkg::word_t   memWData,
	output logic [3:0]       memStrb,
	output logic             memWrite,
	input  rv32Pkg::word_t   memRData,
	output logic             rdWrite,
	output rv32Pkg::regIdx_t rdIdx,
	output rv32Pkg::word_t   rdData
);
	import rv32Pkg::*;

	word_t rs1Data;
	word_t rs2Data;

	rv32CtrlIf ctrlBus ();

	rv32Decoder decoder (
		.inst (inst),
		.ctrl (ctrlBus.dec)
	);

	// retirement ports double as the write-back lines
	rv32RegFile regFile (
		.clk     (clk),
		.rstN    (rstN),
		.rs1Idx  (inst[19:15]),
		.rs2Idx  (inst[24:20]),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data),
		.wbEn    (rdWrite),
		.wbIdx   (rdIdx),
		.wbData  (rdData)
	);

	rv32Execute #(
		.resetPc (resetPc)
	) execute (
		.clk      (clk),
		.rstN     (rstN),
		.ctrl     (ctrlBus.exe),
		.inst     (inst),
		.rs1Data  (rs1Data),
		.rs2Data  (rs2Data),
		.memRData (memRData),
		.pc       (pc),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memStrb  (memStrb),
		.memWrite (memWrite),
		.wbEn     (rdWrite),
		.wbIdx    (rdIdx),
		.wbData   (rdData)
	);

endmodule

`default_nettype wire

// File: rv32CoreTb.sv
`default_nettype none

module rv32CoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] startPc = 32'h0000_0040;
	localparam logic [31:0] nopInst = 32'h0000_0013;
	// sw x0, 0(x0) and addi x1, x0, 1
	localparam logic [31:0] probeStore = 32'h0000_2023;
	localparam logic [31:0] probeAddi  = 32'h0010_0093;
	localparam int numCycles = 2000;

	logic        clk;
	logic        rstN;
	logic [31:0] pc;
	logic [31:0] inst;
	logic [31:0] memAddr;
	logic [31:0] memWData;
	logic [3:0]  memStrb;
	logic        memWrite;
	logic [31:0] memRData;
	logic        rdWrite;
	logic [4:0]  rdIdx;
	logic [31:0] rdData;

	logic [31:0] imem [256];
	logic [31:0] dmem [64];
	logic [31:0] firstInst;

	// reference model state
	logic [31:0] mRegs [32];
	logic [31:0] mMem [64];
	logic [31:0] mPc;

	int seed = 18;
	int errors = 0;
	int checks = 0;
	int loads = 0;
	int stores = 0;
	int taken = 0;

	rv32Core #(
		.resetPc (startPc)
	) dut0 (
		.clk      (clk),
		.rstN     (rstN),
		.pc       (pc),
		.inst     (inst),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memStrb  (memStrb),
		.memWrite (memWrite),
		.memRData (memRData),
		.rdWrite  (rdWrite),
		.rdIdx    (rdIdx),
		.rdData   (rdData)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// both memories answer combinationally
	assign inst     = (pc[31:10] == '0) ? imem[pc[9:2]] : nopInst;
	assign memRData = (memAddr[31:8] == '0) ? dmem[memAddr[7:2]] : 32'd0;

	always @(posedge clk) begin
		if (memWrite && (memAddr[31:8] == '0)) begin
			dmem[memAddr[7:2]] <= mergeBytes(dmem[memAddr[7:2]], memWData, memStrb);
		end
	end

	function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [3:0] laneStrobe(input logic [1:0] size, input logic [1:0] offs);
		case (size)
			2'd0:    return 4'b0001 << offs;
			2'd1:    return 4'b0011 << offs;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
			input logic [31:0] x, input logic [31:0] y);
		logic signed [31:0] sx;
		sx = x;
		case (f3)
			3'd0:    return alt ? x - y : x + y;
			3'd1:    return x << y[4:0];
			3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'd3:    return (x < y) ? 32'd1 : 32'd0;
			3'd4:    return x ^ y;
			3'd5: begin
				if (alt) begin
					return sx >>> y[4:0];
				end
				return x >> y[4:0];
			end
			3'd6:    return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic [31:0] encodeBranch(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encodeJal(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic checkValue(input string test, input string field,
			input logic [31:0] expVal, input logic [31:0] actVal);
		checks++;
		assert (actVal === expVal) else begin
			errors++;
			$display("mismatch %s %s at pc %h: expected %h, actual %h",
				test, field, mPc, expVal, actVal);
		end
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] imm;
		int          fwd;
		int          tgt;
		for (int i = 0; i < 255; i++) begin
			r   = $random(seed);
			s   = $random(seed);
			rd  = r[8:4];
			rs1 = r[13:9];
			rs2 = r[18:14];
			f3  = r[21:19];
			imm = s[11:0];
			// target in words, backward now and then
			fwd = i + int'(s[1:0]) + 1;
			if (fwd > 255) begin
				fwd = 255;
			end
			tgt = (s[3:2] == 2'b11) ? i - int'(s[1:0]) - 1 : fwd;
			if (tgt < 0) begin
				tgt = fwd;
			end
			case (r[3:0])
				4'd0, 4'd1, 4'd2, 4'd3: begin
					if (f3 == 3'd1) begin
						imm[11:5] = 7'd0;
					end
					if (f3 == 3'd5) begin
						imm[11:5] = {1'b0, s[10], 5'd0};
					end
					imem[i] = {imm, rs1, f3, rd, 7'b0010011};
				end
				4'd4, 4'd5: begin
					imm[11:5] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, s[0], 5'd0} : 7'd0;
					imem[i] = {imm[11:5], rs2, rs1, f3, rd, 7'b0110011};
				end
				4'd6: imem[i] = {s[31:12], rd, 7'b0110111};
				4'd7: imem[i] = {s[31:12], rd, 7'b0010111};
				4'd8, 4'd9, 4'd10, 4'd11: begin
					// x0 base, aligned address inside the 256 byte region
					if (r[3:0] > 4'd9) begin
						f3 = {1'b0, (r[20:19] == 2'd3) ? 2'd2 : r[20:19]};
					end else if (f3 == 3'd3 || f3 > 3'd5) begin
						f3 = 3'd2;
					end
					imm = {4'd0, s[15:8]};
					if (f3[1:0] != 2'd0) begin
						imm[0] = 1'b0;
					end
					if (f3[1:0] == 2'd2) begin
						imm[1] = 1'b0;
					end
					if (r[3:0] > 4'd9) begin
						imem[i] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
					end else begin
						imem[i] = {imm, 5'd0, f3, rd, 7'b0000011};
					end
				end
				4'd12, 4'd13: begin
					if (f3[2:1] == 2'b01) begin
						f3[2] = 1'b1;
					end
					imem[i] = encodeBranch(13'((tgt - i) * 4), rs2, rs1, f3);
				end
				4'd14: begin
					if (s[20]) begin
						imem[i] = encodeJal(21'((fwd - i) * 4), rd);
					end else begin
						imem[i] = {12'(int'(s[7:0]) * 4), 5'd0, 3'd0, rd, 7'b1100111};
					end
				end
				default: imem[i] = {s[31:7], 7'b0001011};
			endcase
		end
		// last word wraps back to address 0
		imem[255] = encodeJal(21'(-255 * 4), 5'd0);
	endtask

	// one instruction of the model, checked against the DUT and then committed
	task automatic stepModel();
		logic [31:0] in;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [31:0] word;
		logic [31:0] res;
		logic [31:0] next;
		logic [31:0] mask;
		logic [3:0]  strb;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic        wr;
		logic        st;
		logic        cond;
		string       test;
		in   = (mPc[31:10] == '0) ? imem[mPc[9:2]] : nopInst;
		f3   = in[14:12];
		rd   = in[11:7];
		a    = mRegs[in[19:15]];
		b    = mRegs[in[24:20]];
		ea   = 32'd0;
		res  = 32'd0;
		next = mPc + 32'd4;
		strb = 4'd0;
		wr   = 1'b0;
		st   = 1'b0;
		test = "illegal";
		case (in[6:0])
			7'b0110111: begin
				test = "lui";
				wr   = 1'b1;
				res  = {in[31:12], 12'd0};
			end
			7'b0010111: begin
				test = "auipc";
				wr   = 1'b1;
				res  = mPc + {in[31:12], 12'd0};
			end
			7'b1101111: begin
				test = "jal";
				wr   = 1'b1;
				res  = mPc + 32'd4;
				next = mPc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
			end
			7'b1100111: begin
				test = "jalr";
				wr   = 1'b1;
				res  = mPc + 32'd4;
				next = (a + {{20{in[31]}}, in[31:20]}) & ~32'd1;
			end
			7'b1100011: begin
				test = "branch";
				case (f3)
					3'd0:    cond = (a == b);
					3'd1:    cond = (a != b);
					3'd4:    cond = ($signed(a) < $signed(b));
					3'd5:    cond = ($signed(a) >= $signed(b));
					3'd6:    cond = (a < b);
					3'd7:    cond = (a >= b);
					default: cond = 1'b0;
				endcase
				if (cond) begin
					next = mPc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
				end
			end
			7'b0000011: begin
				test = "load";
				wr   = 1'b1;
				ea   = a + {{20{in[31]}}, in[31:20]};
				strb = laneStrobe(f3[1:0], ea[1:0]);
				word = mMem[ea[7:2]] >> (8 * ea[1:0]);
				case (f3)
					3'd0:    res = {{24{word[7]}}, word[7:0]};
					3'd1:    res = {{16{word[15]}}, word[15:0]};
					3'd4:    res = {24'd0, word[7:0]};
					3'd5:    res = {16'd0, word[15:0]};
					default: res = word;
				endcase
				loads++;
			end
			7'b0100011: begin
				test = "store";
				st   = 1'b1;
				ea   = a + {{20{in[31]}}, in[31:25], in[11:7]};
				strb = laneStrobe(f3[1:0], ea[1:0]);
				stores++;
			end
			7'b0010011: begin
				test = "opImm";
				wr   = 1'b1;
				res  = refAlu(f3, (f3 == 3'd5) && in[30], a, {{20{in[31]}}, in[31:20]});
			end
			7'b0110011: begin
				test = "opReg";
				wr   = 1'b1;
				res  = refAlu(f3, in[30], a, b);
			end
			default: ;
		endcase

		checkValue(test, "pc", mPc, pc);
		checkValue(test, "rdWrite", 32'(wr), 32'(rdWrite));
		if (wr) begin
			checkValue(test, "rdIdx", 32'(rd), 32'(rdIdx));
			checkValue(test, "rdData", res, rdData);
		end
		checkValue(test, "memWrite", 32'(st), 32'(memWrite));
		checkValue(test, "memStrb", 32'(strb), 32'(memStrb));
		if (strb != 4'd0) begin
			checkValue(test, "memAddr", ea & ~32'd3, memAddr);
		end
		if (st) begin
			mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
			checkValue(test, "memWData", (b << (8 * ea[1:0])) & mask, memWData & mask);
			mMem[ea[7:2]] = mergeBytes(mMem[ea[7:2]], b << (8 * ea[1:0]), strb);
		end
		// x0 stays zero in the model
		if (wr && (rd != 5'd0)) begin
			mRegs[rd] = res;
		end
		if (next != mPc + 32'd4) begin
			taken++;
		end
		mPc = next;
	endtask

	initial begin
		rstN = 1'b0;
		buildProgram();
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'h9e37_79b9 * 32'(i + 1);
			mMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			mRegs[i] = 32'd0;
		end
		mPc = startPc;

		// a store and then a register write sit at the reset pc while reset holds them off
		firstInst = imem[startPc[9:2]];
		imem[startPc[9:2]] = probeStore;
		for (int c = 0; c < 2; c++) begin
			@(posedge clk);
			#1;
			checkValue("reset", "pc", startPc, pc);
			checkValue("reset", "rdWrite", 32'd0, 32'(rdWrite));
			checkValue("reset", "memWrite", 32'd0, 32'(memWrite));
			imem[startPc[9:2]] = (c == 0) ? probeAddi : firstInst;
		end
		rstN = 1'b1;

		for (int c = 0; c < numCycles; c++) begin
			@(negedge clk);
			stepModel();
		end

		assert (loads > 0 && stores > 0 && taken > 0) else begin
			errors++;
			$display("the program never reached a load, a store and a taken jump");
		end
		$display("%0d checks, %0d errors, %0d loads, %0d stores, %0d taken jumps",
			checks, errors, loads, stores, taken);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rv32CtrlIf.sv
`default_nettype none

interface rv32CtrlIf;
	import rv32Pkg::*;

	word_t    imm;
	aluOp_t   aluOp;
	logic     aSelPc;
	logic     bSelImm;
	brOp_t    brOp;
	logic     jalrTarget;
	wbSel_t   wbSel;
	logic     regWrite;
	logic     memRead;
	logic     memWrite;
	memSize_t memSize;
	logic     memSigned;

	modport dec (
		output imm, aluOp, aSelPc, bSelImm, brOp, jalrTarget,
		output wbSel, regWrite, memRead, memWrite, memSize, memSigned
	);

	modport exe (
		input imm, aluOp, aSelPc, bSelImm, brOp, jalrTarget,
		input wbSel, regWrite, memRead, memWrite, memSize, memSigned
	);

endinterface

`default_nettype wire

// File: rv32Decoder.sv
`default_nettype none

module rv32Decoder (
	input  rv32Pkg::word_t inst,
	rv32CtrlIf.dec         ctrl
);
	import rv32Pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic       funct7b5;
	word_t      immI;
	word_t      immS;
	word_t      immB;
	word_t      immU;
	word_t      immJ;

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7b5 = inst[30];

	// immediate formats, all sign extended from bit 31
	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// alt picks sub or sra
	function automatic aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? aluSub : aluAdd;
			3'b001:  return aluSll;
			3'b010:  return aluSlt;
			3'b011:  return aluSltu;
			3'b100:  return aluXor;
			3'b101:  return alt ? aluSra : aluSrl;
			3'b110:  return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	function automatic memSize_t sizeFromFunct3(input logic [1:0] f3Low);
		case (f3Low)
			2'b00:   return sizeByte;
			2'b01:   return sizeHalf;
			default: return sizeWord;
		endcase
	endfunction

	always_comb begin
		// unknown opcodes fall through as a plain pc+4 step
		ctrl.imm        = immI;
		ctrl.aluOp      = aluAdd;
		ctrl.aSelPc     = 1'b0;
		ctrl.bSelImm    = 1'b0;
		ctrl.brOp       = brNone;
		ctrl.jalrTarget = 1'b0;
		ctrl.wbSel      = wbAlu;
		ctrl.regWrite   = 1'b0;
		ctrl.memRead    = 1'b0;
		ctrl.memWrite   = 1'b0;
		ctrl.memSize    = sizeFromFunct3(funct3[1:0]);
		ctrl.memSigned  = ~funct3[2];

		case (opcode)
			opLui: begin
				ctrl.imm      = immU;
				ctrl.aluOp    = aluPassB;
				ctrl.bSelImm  = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opAuipc: begin
				ctrl.imm      = immU;
				ctrl.aSelPc   = 1'b1;
				ctrl.bSelImm  = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opJal: begin
				ctrl.imm      = immJ;
				ctrl.brOp     = brJump;
				ctrl.wbSel    = wbPc4;
				ctrl.regWrite = 1'b1;
			end
			opJalr: begin
				ctrl.bSelImm    = 1'b1;
				ctrl.jalrTarget = 1'b1;
				ctrl.wbSel      = wbPc4;
				ctrl.regWrite   = 1'b1;
			end
			opBranch: begin
				ctrl.imm = immB;
				case (funct3)
					3'b000:  ctrl.brOp = brEq;
					3'b001:  ctrl.brOp = brNe;
					3'b100:  ctrl.brOp = brLt;
					3'b101:  ctrl.brOp = brGe;
					3'b110:  ctrl.brOp = brLtu;
					3'b111:  ctrl.brOp = brGeu;
					default: ctrl.brOp = brNone;
				endcase
			end
			opLoad: begin
				ctrl.bSelImm  = 1'b1;
				ctrl.wbSel    = wbLoad;
				ctrl.memRead  = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
				ctrl.regWrite = ctrl.memRead;
			end
			opStore: begin
				ctrl.imm      = immS;
				ctrl.bSelImm  = 1'b1;
				ctrl.memWrite = funct3 inside {3'b000, 3'b001, 3'b010};
			end
			opImm: begin
				ctrl.aluOp    = aluFromFunct3(funct3, (funct3 == 3'b101) & funct7b5);
				ctrl.bSelImm  = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opReg: begin
				ctrl.aluOp    = aluFromFunct3(funct3, funct7b5);
				ctrl.regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rv32Execute.sv
`default_nettype none

module rv32Execute #(
	parameter rv32Pkg::word_t resetPc = '0
) (
	input  logic             clk,
	input  logic             rstN,
	rv32CtrlIf.exe           ctrl,
	input  rv32Pkg::word_t   inst,
	input  rv32Pkg::word_t   rs1Data,
	input  rv32Pkg::word_t   rs2Data,
	input  rv32Pkg::word_t   memRData,
	output rv32Pkg::word_t   pc,
	output rv32Pkg::word_t   memAddr,
	output rv32Pkg::word_t   memWData,
	output logic [3:0]       memStrb,
	output logic             memWrite,
	output logic             wbEn,
	output rv32Pkg::regIdx_t wbIdx,
	output rv32Pkg::word_t   wbData
);
	import rv32Pkg::*;

	word_t      pcReg;
	word_t      pcPlus4;
	word_t      nextPc;
	word_t      opA;
	word_t      opB;
	word_t      aluResult;
	word_t      loadData;
	logic [4:0] shamt;
	logic [3:0] strobe;
	logic       brTaken;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcReg <= resetPc;
		end else begin
			pcReg <= nextPc;
		end
	end

	assign pc      = pcReg;
	assign pcPlus4 = pcReg + 32'd4;

	assign opA   = ctrl.aSelPc ? pcReg : rs1Data;
	assign opB   = ctrl.bSelImm ? ctrl.imm : rs2Data;
	assign shamt = opB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   aluResult = opA + opB;
			aluSub:   aluResult = opA - opB;
			aluSll:   aluResult = opA << shamt;
			aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu:  aluResult = {31'b0, opA < opB};
			aluXor:   aluResult = opA ^ opB;
			aluSrl:   aluResult = opA >> shamt;
			aluSra:   aluResult = $signed(opA) >>> shamt;
			aluOr:    aluResult = opA | opB;
			aluAnd:   aluResult = opA & opB;
			default:  aluResult = opB;
		endcase
	end

	// branch compare always on register values
	always_comb begin
		case (ctrl.brOp)
			brEq:    brTaken = (rs1Data == rs2Data);
			brNe:    brTaken = (rs1Data != rs2Data);
			brLt:    brTaken = ($signed(rs1Data) < $signed(rs2Data));
			brGe:    brTaken = ($signed(rs1Data) >= $signed(rs2Data));
			brLtu:   brTaken = (rs1Data < rs2Data);
			brGeu:   brTaken = (rs1Data >= rs2Data);
			brJump:  brTaken = 1'b1;
			default: brTaken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.jalrTarget) begin
			nextPc = {aluResult[31:1], 1'b0};
		end else if (brTaken) begin
			nextPc = pcReg + ctrl.imm;
		end else begin
			nextPc = pcPlus4;
		end
	end

	rv32LoadStore lsu (
		.addr       (aluResult),
		.size       (ctrl.memSize),
		.signedLoad (ctrl.memSigned),
		.storeData  (rs2Data),
		.rawRData   (memRData),
		.strobe     (strobe),
		.laneWData  (memWData),
		.loadData   (loadData)
	);

	assign memAddr  = {aluResult[31:2], 2'b00};
	// lanes shown for any access, zero otherwise
	assign memStrb  = (ctrl.memRead | ctrl.memWrite) ? strobe : 4'b0000;
	assign memWrite = ctrl.memWrite & rstN;

	always_comb begin
		case (ctrl.wbSel)
			wbLoad:  wbData = loadData;
			wbPc4:   wbData = pcPlus4;
			default: wbData = aluResult;
		endcase
	end

	assign wbEn  = ctrl.regWrite & rstN;
	assign wbIdx = inst[11:7];

endmodule

`default_nettype wire

// File: rv32LoadStore.sv
`default_nettype none

module rv32LoadStore (
	input  rv32Pkg::word_t    addr,
	input  rv32Pkg::memSize_t size,
	input  logic              signedLoad,
	input  rv32Pkg::word_t    storeData,
	input  rv32Pkg::word_t    rawRData,
	output logic [3:0]        strobe,
	output rv32Pkg::word_t    laneWData,
	output rv32Pkg::word_t    loadData
);
	import rv32Pkg::*;

	logic [1:0] offs;
	word_t      byteShifted;
	word_t      halfShifted;

	assign offs = addr[1:0];

	// addressed lane moved down to bit 0
	assign byteShifted = rawRData >> {offs, 3'b000};
	assign halfShifted = rawRData >> {offs[1], 4'b0000};

	// store lanes and strobes
	always_comb begin
		case (size)
			sizeByte: begin
				strobe    = 4'b0001 << offs;
				laneWData = storeData << {offs, 3'b000};
			end
			sizeHalf: begin
				strobe    = 4'b0011 << {offs[1], 1'b0};
				laneWData = storeData << {offs[1], 4'b0000};
			end
			default: begin
				strobe    = 4'b1111;
				laneWData = storeData;
			end
		endcase
	end

	// load extraction, zero or sign fill
	always_comb begin
		case (size)
			sizeByte:
				loadData = {{24{signedLoad & byteShifted[7]}}, byteShifted[7:0]};
			sizeHalf:
				loadData = {{16{signedLoad & halfShifted[15]}}, halfShifted[15:0]};
			default:
				loadData = rawRData;
		endcase
	end

endmodule

`default_nettype wire

// File: rv32Pkg.sv
`default_nettype none

package rv32Pkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regIdx_t;
	typedef logic [6:0]  opcode_t;

	// control field types
	typedef logic [3:0] aluOp_t;
	typedef logic [2:0] brOp_t;
	typedef logic [1:0] wbSel_t;
	typedef logic [1:0] memSize_t;

	// opcode groups
	localparam opcode_t opLui    = 7'b0110111;
	localparam opcode_t opAuipc  = 7'b0010111;
	localparam opcode_t opJal    = 7'b1101111;
	localparam opcode_t opJalr   = 7'b1100111;
	localparam opcode_t opBranch = 7'b1100011;
	localparam opcode_t opLoad   = 7'b0000011;
	localparam opcode_t opStore  = 7'b0100011;
	localparam opcode_t opImm    = 7'b0010011;
	localparam opcode_t opReg    = 7'b0110011;

	// alu operations
	localparam aluOp_t aluAdd   = 4'd0;
	localparam aluOp_t aluSub   = 4'd1;
	localparam aluOp_t aluSll   = 4'd2;
	localparam aluOp_t aluSlt   = 4'd3;
	localparam aluOp_t aluSltu  = 4'd4;
	localparam aluOp_t aluXor   = 4'd5;
	localparam aluOp_t aluSrl   = 4'd6;
	localparam aluOp_t aluSra   = 4'd7;
	localparam aluOp_t aluOr    = 4'd8;
	localparam aluOp_t aluAnd   = 4'd9;
	localparam aluOp_t aluPassB = 4'd10;

	// branch conditions
	localparam brOp_t brNone = 3'd0;
	localparam brOp_t brEq   = 3'd1;
	localparam brOp_t brNe   = 3'd2;
	localparam brOp_t brLt   = 3'd3;
	localparam brOp_t brGe   = 3'd4;
	localparam brOp_t brLtu  = 3'd5;
	localparam brOp_t brGeu  = 3'd6;
	localparam brOp_t brJump = 3'd7;

	// write-back sources
	localparam wbSel_t wbAlu  = 2'd0;
	localparam wbSel_t wbLoad = 2'd1;
	localparam wbSel_t wbPc4  = 2'd2;

	// access size, same coding as DataLen
	localparam memSize_t sizeByte = 2'd0;
	localparam memSize_t sizeHalf = 2'd1;
	localparam memSize_t sizeWord = 2'd3;

endpackage

`default_nettype wire

// File: rv32RegFile.sv
`default_nettype none

module rv32RegFile (
	input  logic             clk,
	input  logic             rstN,
	input  rv32Pkg::regIdx_t rs1Idx,
	input  rv32Pkg::regIdx_t rs2Idx,
	output rv32Pkg::word_t   rs1Data,
	output rv32Pkg::word_t   rs2Data,
	input  logic             wbEn,
	input  rv32Pkg::regIdx_t wbIdx,
	input  rv32Pkg::word_t   wbData
);
	import rv32Pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn && (wbIdx != '0)) begin
			regs[wbIdx] <= wbData;
		end
	end

	// x0 reads as zero
	assign rs1Data = (rs1Idx == '0) ? '0 : regs[rs1Idx];
	assign rs2Data = (rs2Idx == '0) ? '0 : regs[rs2Idx];

endmodule

`default_nettype wire
